/* uart_pkg.sv */
package uart_pkg;

  // --------------------
  // Line timing
  // --------------------

  // System clock feeding the transmitter
  localparam logic [31:0] CLK_FREQ_HZ = 32'd250_000_000;

  // Line rate, chosen for 16 clocks per bit
  localparam logic [31:0] BAUD_RATE = 32'd15_625_000;

  // Clocks per bit on the line
  localparam logic [31:0] CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

  // --------------------
  // Data types
  // --------------------

  // One 8N1 character, sent LSB first
  typedef logic [7:0] uart_byte_t;

endpackage

/* cat_pkg.sv */
package cat_pkg;

  // --------------------
  // Frequency and BCD
  // --------------------

  // VFO A frequency in hertz
  typedef logic [31:0] freq_t;

  // Eight packed BCD digits, most significant digit in [31:28]
  typedef logic [31:0] bcd_t;

  // Smallest refused frequency, since eight digits hold up to 99,999,999
  localparam freq_t FREQ_LIMIT = 32'd100_000_000;

  // --------------------
  // FA command
  // --------------------

  // "FA" + eleven digits + ";"
  localparam int unsigned CMD_LEN = 14;

  localparam uart_pkg::uart_byte_t ASCII_F    = 8'h46;
  localparam uart_pkg::uart_byte_t ASCII_A    = 8'h41;
  localparam uart_pkg::uart_byte_t ASCII_ZERO = 8'h30;
  localparam uart_pkg::uart_byte_t ASCII_SEMI = 8'h3b;

  // --------------------
  // AXI4-Lite map
  // --------------------

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // Frequency register, read/write
  localparam axil_addr_t REG_FREQ   = 4'h0;
  // Status, bit 0 busy and bit 1 pending
  localparam axil_addr_t REG_STATUS = 4'h4;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* axil_freq_regs.sv */
`timescale 1ns/1ps

module axil_freq_regs (
  input  logic                clk,
  input  logic                reset,
  // Write address
  input  cat_pkg::axil_addr_t awaddr,
  input  logic                awvalid,
  output logic                awready,
  // Write data, strobes are taken as all-ones
  input  cat_pkg::axil_data_t wdata,
  input  logic [3:0]          wstrb,
  input  logic                wvalid,
  output logic                wready,
  // Write response
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  // Read address
  input  cat_pkg::axil_addr_t araddr,
  input  logic                arvalid,
  output logic                arready,
  // Read data
  output cat_pkg::axil_data_t rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  // To the command sequencer
  output cat_pkg::freq_t      new_freq,
  output logic                new_freq_valid,
  // Status from the command sequencer
  input  logic                busy,
  input  logic                pending
);

  import cat_pkg::*;

  freq_t freq_reg;
  logic  wr_fire;
  logic  rd_fire;
  logic  wr_is_freq;
  logic  wr_in_range;
  logic  wr_freq_ok;
  logic  wr_err;

  // Handshake completes while the ready pulse is up
  assign wr_fire = awready && wready && awvalid && wvalid;
  assign rd_fire = arready && arvalid;

  // Write decode
  assign wr_is_freq  = (awaddr == REG_FREQ);
  assign wr_in_range = (wdata < FREQ_LIMIT);
  assign wr_freq_ok  = wr_is_freq && wr_in_range;
  // Unmapped address or out of range frequency
  assign wr_err = !(wr_is_freq || (awaddr == REG_STATUS)) || (wr_is_freq && !wr_in_range);

  assign new_freq = freq_reg;

  // --------------------
  // Write channel
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      awready        <= 1'b0;
      wready         <= 1'b0;
      bvalid         <= 1'b0;
      new_freq_valid <= 1'b0;
      freq_reg       <= '0;
    end else begin
      // One-cycle ready pulse once address and data are both offered,
      // held off while a response still waits for bready
      awready <= !awready && awvalid && wvalid && !bvalid;
      wready  <= !awready && awvalid && wvalid && !bvalid;

      // Every accepted frequency goes to the sequencer, even a repeat
      new_freq_valid <= wr_fire && wr_freq_ok;
      if (wr_fire && wr_freq_ok) begin
        freq_reg <= wdata;
      end

      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // --------------------
  // Read channel
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= !arready && arvalid && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (araddr)
        REG_FREQ: begin
          rdata <= axil_data_t'(freq_reg);
          rresp <= RESP_OKAY;
        end
        REG_STATUS: begin
          rdata <= axil_data_t'({pending, busy});
          rresp <= RESP_OKAY;
        end
        default: begin
          rdata <= '0;
          rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

/* bin_to_bcd.sv */
`timescale 1ns/1ps

module bin_to_bcd (
  input  logic           clk,
  input  logic           reset,
  input  logic           conv_start,
  input  cat_pkg::freq_t bin_value,
  output logic           conv_done,
  output cat_pkg::bcd_t  bcd_value
);

  import cat_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADJUST,
    ST_SHIFT,
    ST_DONE
  } state_t;

  state_t     state;
  logic [4:0] step_cnt;
  freq_t      bin_reg;
  bcd_t       bcd_reg;
  bcd_t       bcd_adj;

  // Add 3 to every digit of 5 or more before the next shift
  always_comb begin
    for (int i = 0; i < $bits(bcd_t) / 4; i++) begin
      bcd_adj[4*i +: 4] = (bcd_reg[4*i +: 4] >= 4'd5) ? bcd_reg[4*i +: 4] + 4'd3
                                                       : bcd_reg[4*i +: 4];
    end
  end

  // --------------------
  // Step FSM
  // --------------------

  // Load, then 32 adjust/shift pairs, then one done cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (conv_start) begin
            state    <= ST_ADJUST;
            step_cnt <= '0;
          end
        end
        ST_ADJUST: begin
          state <= ST_SHIFT;
        end
        ST_SHIFT: begin
          // Last bit of the binary word shifted in
          if (step_cnt == 5'($bits(freq_t) - 1)) begin
            state <= ST_DONE;
          end else begin
            step_cnt <= step_cnt + 5'd1;
            state    <= ST_ADJUST;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Datapath, binary word shifts MSB first into the digit field
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && conv_start) begin
      bcd_reg <= '0;
      bin_reg <= bin_value;
    end else if (state == ST_ADJUST) begin
      bcd_reg <= bcd_adj;
    end else if (state == ST_SHIFT) begin
      {bcd_reg, bin_reg} <= {bcd_reg[$bits(bcd_t)-2:0], bin_reg, 1'b0};
    end
  end

  assign conv_done = (state == ST_DONE);
  // Held until the next load
  assign bcd_value = bcd_reg;

endmodule

/* cat_cmd_sequencer.sv */
`timescale 1ns/1ps

module cat_cmd_sequencer (
  input  logic                 clk,
  input  logic                 reset,
  input  cat_pkg::freq_t       new_freq,
  input  logic                 new_freq_valid,
  input  logic                 conv_done,
  input  cat_pkg::bcd_t        bcd_value,
  input  logic                 tx_ready,
  output logic                 busy,
  output logic                 pending,
  output logic                 conv_start,
  output cat_pkg::freq_t       bin_value,
  output uart_pkg::uart_byte_t tx_data,
  output logic                 tx_valid
);

  import cat_pkg::*;
  import uart_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CONVERT,
    ST_SEND
  } state_t;

  state_t     state;
  freq_t      last_freq;
  freq_t      pend_freq;
  freq_t      next_last;
  logic       pend_valid;
  logic       take;
  logic [3:0] byte_idx;
  logic [3:0] digit_idx;
  bcd_t       digit_field;
  uart_byte_t digit_char;

  // Pending value moves into conversion when idle
  assign take      = (state == ST_IDLE) && pend_valid;
  // What counts as already sent after this edge
  assign next_last = take ? pend_freq : last_freq;

  assign busy      = (state != ST_IDLE);
  assign pending   = pend_valid;
  assign tx_valid  = (state == ST_SEND);
  // Last sent value is also the converter input
  assign bin_value = last_freq;

  // --------------------
  // Pending slot
  // --------------------

  // Newest write wins, one value deep
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_valid <= 1'b0;
    end else if (new_freq_valid) begin
      // A repeat of the sent value cancels anything older
      pend_valid <= (new_freq != next_last);
    end else if (take) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (new_freq_valid && (new_freq != next_last)) begin
      pend_freq <= new_freq;
    end
  end

  // --------------------
  // Command FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      last_freq  <= '0;
      conv_start <= 1'b0;
      byte_idx   <= '0;
    end else begin
      conv_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (take) begin
            last_freq  <= pend_freq;
            conv_start <= 1'b1;
            state      <= ST_CONVERT;
          end
        end
        ST_CONVERT: begin
          if (conv_done) begin
            byte_idx <= '0;
            state    <= ST_SEND;
          end
        end
        ST_SEND: begin
          // Bytes go back to back, paced by the transmitter
          if (tx_valid && tx_ready) begin
            if (byte_idx == 4'(CMD_LEN - 1)) begin
              state <= ST_IDLE;
            end else begin
              byte_idx <= byte_idx + 4'd1;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // Byte select
  // --------------------

  // Digits sit in bytes 5 to 12, most significant first
  always_comb begin
    digit_idx   = byte_idx - 4'd5;
    digit_field = bcd_value << {digit_idx, 2'b00};
    digit_char  = ASCII_ZERO | {4'h0, digit_field[31:28]};
    case (byte_idx)
      4'd0:       tx_data = ASCII_F;
      4'd1:       tx_data = ASCII_A;
      // Three leading zeros pad the 8 digits to 11
      4'd2, 4'd3, 4'd4: tx_data = ASCII_ZERO;
      4'd13:      tx_data = ASCII_SEMI;
      default:    tx_data = digit_char;
    endcase
  end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic                 clk,
  input  logic                 reset,
  input  uart_pkg::uart_byte_t tx_data,
  input  logic                 tx_valid,
  output logic                 tx_ready,
  output logic                 uart_txd
);

  import uart_pkg::*;

  logic [15:0] baud_cnt;
  logic [3:0]  bit_cnt;
  logic [9:0]  shift_reg;
  logic        active;
  logic        bit_tick;
  logic        frame_end;

  // End of the current bit
  assign bit_tick  = (baud_cnt == 16'd0);
  // Leave one stop cycle to idle, so a new byte starts right after it
  assign frame_end = (bit_cnt == 4'd0) && (baud_cnt == 16'd1);

  assign tx_ready = !active;
  // Line idles high
  assign uart_txd = shift_reg[0];

  // --------------------
  // Frame shifter
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      shift_reg <= '1;
    end else if (tx_valid && !active) begin
      // Stop, data LSB first, start
      active    <= 1'b1;
      baud_cnt  <= 16'(CLKS_PER_BIT - 1);
      bit_cnt   <= 4'd9;
      shift_reg <= {1'b1, tx_data, 1'b0};
    end else if (active) begin
      if (frame_end) begin
        active <= 1'b0;
      end
      if (bit_tick) begin
        baud_cnt  <= 16'(CLKS_PER_BIT - 1);
        bit_cnt   <= bit_cnt - 4'd1;
        // Ones fill in behind the stop bit
        shift_reg <= {1'b1, shift_reg[9:1]};
      end else begin
        baud_cnt <= baud_cnt - 16'd1;
      end
    end
  end

endmodule

/* ext_amp_ctrl.sv */
`timescale 1ns/1ps

module ext_amp_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  cat_pkg::axil_addr_t awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  cat_pkg::axil_data_t wdata,
  input  logic [3:0]          wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  cat_pkg::axil_addr_t araddr,
  input  logic                arvalid,
  output logic                arready,
  output cat_pkg::axil_data_t rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  output logic                uart_txd
);

  import cat_pkg::*;
  import uart_pkg::*;

  // Register slave and sequencer
  freq_t      new_freq;
  logic       new_freq_valid;
  logic       busy;
  logic       pending;
  // Sequencer and converter
  logic       conv_start;
  logic       conv_done;
  freq_t      bin_value;
  bcd_t       bcd_value;
  // Sequencer and transmitter
  uart_byte_t tx_data;
  logic       tx_valid;
  logic       tx_ready;

  axil_freq_regs u_regs (
    .clk            (clk),
    .reset          (reset),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wstrb          (wstrb),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .new_freq       (new_freq),
    .new_freq_valid (new_freq_valid),
    .busy           (busy),
    .pending        (pending)
  );

  cat_cmd_sequencer u_seq (
    .clk            (clk),
    .reset          (reset),
    .new_freq       (new_freq),
    .new_freq_valid (new_freq_valid),
    .conv_done      (conv_done),
    .bcd_value      (bcd_value),
    .tx_ready       (tx_ready),
    .busy           (busy),
    .pending        (pending),
    .conv_start     (conv_start),
    .bin_value      (bin_value),
    .tx_data        (tx_data),
    .tx_valid       (tx_valid)
  );

  bin_to_bcd u_bcd (
    .clk        (clk),
    .reset      (reset),
    .conv_start (conv_start),
    .bin_value  (bin_value),
    .conv_done  (conv_done),
    .bcd_value  (bcd_value)
  );

  uart_tx u_tx (
    .clk      (clk),
    .reset    (reset),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .uart_txd (uart_txd)
  );

endmodule

/* ext_amp_ctrl_assertions.sv */
`timescale 1ns/1ps

module ext_amp_ctrl_assertions (
  input logic                 clk,
  input logic                 reset,
  input logic                 bvalid,
  input logic                 bready,
  input logic                 rvalid,
  input logic                 rready,
  input logic                 uart_txd,
  input logic                 busy,
  input logic                 tx_ready,
  input logic                 tx_valid,
  input uart_pkg::uart_byte_t tx_data
);

  int unsigned fail_count = 0;

  // Write response waits for the host
  bvalid_held: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  // Read data waits for the host
  rvalid_held: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // Idle sequencer and idle transmitter, line sits high
  line_idle_high: assert property (@(posedge clk) disable iff (reset)
    !busy && tx_ready |-> uart_txd)
    else begin
      $error("uart_txd low while nothing is being sent");
      fail_count++;
    end

  // Offered byte holds until the transmitter takes it
  tx_data_stable: assert property (@(posedge clk) disable iff (reset)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else begin
      $error("tx_data or tx_valid changed while waiting for tx_ready");
      fail_count++;
    end

endmodule

bind ext_amp_ctrl ext_amp_ctrl_assertions u_assert (
  .clk      (clk),
  .reset    (reset),
  .bvalid   (bvalid),
  .bready   (bready),
  .rvalid   (rvalid),
  .rready   (rready),
  .uart_txd (uart_txd),
  .busy     (busy),
  .tx_ready (tx_ready),
  .tx_valid (tx_valid),
  .tx_data  (tx_data)
);

/* tb_ext_amp_ctrl.sv */
`timescale 1ns/1ps

module tb_ext_amp_ctrl;

  import cat_pkg::*;
  import uart_pkg::*;

  // --------------------
  // Run constants
  // --------------------

  localparam logic [31:0] LFSR_SEED = 32'hef79;
  localparam int N_FIXED = 4;
  localparam int N_RANDOM = 6;
  // Fixed and random singles, plus first and last of the burst
  localparam int N_CMDS = N_FIXED + N_RANDOM + 2;
  localparam int N_QUIET = 4;
  localparam int BIT_CYCLES = int'(CLKS_PER_BIT);
  localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
  localparam int CMD_CYCLES = int'(CMD_LEN) * FRAME_CYCLES;
  localparam int QUIET_CYCLES = 400;
  localparam int HANDSHAKE_LIMIT = 64;
  // Command time plus conversion and bus overhead, quiet windows, margin
  localparam int WATCHDOG_CYCLES = N_CMDS * (CMD_CYCLES + 200) + N_QUIET * QUIET_CYCLES + 1000;

  localparam freq_t FIXED_FREQS [N_FIXED] = '{
    32'd14_074_000,
    32'd1,
    32'd99_999_999,
    32'd7_000_100
  };

  logic        clk;
  logic        reset;
  axil_addr_t  awaddr;
  logic        awvalid;
  logic        awready;
  axil_data_t  wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  axil_addr_t  araddr;
  logic        arvalid;
  logic        arready;
  axil_data_t  rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        uart_txd;

  // Decoded bytes and the frequencies whose commands are still due
  uart_byte_t  rx_q[$];
  freq_t       exp_q[$];
  int          rx_count = 0;
  int          cmd_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  logic [31:0] lfsr_state;

  ext_amp_ctrl dut (
    .clk      (clk),
    .reset    (reset),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .uart_txd (uart_txd)
  );

  // 4 ns period
  initial clk = 1'b0;
  always #2 clk = ~clk;

  // --------------------
  // Reference and helpers
  // --------------------

  // FA command with byte k in bits [8k+7:8k] and eleven digits from decimal division
  function automatic logic [8*CMD_LEN-1:0] expected_cmd(input freq_t freq);
    logic [8*CMD_LEN-1:0] cmd;
    freq_t rest;
    cmd = '0;
    rest = freq;
    cmd[7:0] = "F";
    cmd[15:8] = "A";
    // Least significant digit lands in byte 12
    for (int k = 12; k >= 2; k--) begin
      cmd[8*k +: 8] = "0" + 8'(rest % 10);
      rest = rest / 10;
    end
    cmd[8*13 +: 8] = ";";
    return cmd;
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Takes 27 bits with one LFSR step per bit and folds them below the limit
  task automatic take_random_freq(output freq_t f);
    f = '0;
    for (int i = 0; i < 27; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      f = {f[30:0], lfsr_state[0]};
    end
    f = f % FREQ_LIMIT;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got == exp) else begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  // Host side of one write
  // Ready seen at a falling edge means the next rising edge takes it
  task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                           output logic [1:0] resp);
    int waited;
    waited = 0;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    wvalid  = 1'b1;
    bready  = 1'b0;
    while (!awready && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (awready) else begin
      $display("Write to address %h was never accepted", addr);
      error_count++;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waited  = 0;
    while (!bvalid && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (bvalid) else begin
      $display("No response came for the write to address %h", addr);
      error_count++;
    end
    resp = bresp;
    // Response waits two cycles for the host
    repeat (2) @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  // Reads of mapped registers always answer OKAY
  task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
    int waited;
    waited = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    while (!arready && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (arready) else begin
      $display("Read of address %h was never accepted", addr);
      error_count++;
    end
    @(negedge clk);
    arvalid = 1'b0;
    waited  = 0;
    while (!rvalid && waited < HANDSHAKE_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    assert (rvalid) else begin
      $display("No data came for the read of address %h", addr);
      error_count++;
    end
    data = rdata;
    check_value("rresp", 32'(rresp), 32'(RESP_OKAY));
    // Read data waits two cycles for the host
    repeat (2) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Accepted write whose command is expected on the line
  task automatic send_freq(input freq_t freq);
    logic [1:0] resp;
    exp_q.push_back(freq);
    write_reg(REG_FREQ, freq, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
  endtask

  task automatic wait_commands(input int target);
    int waited;
    waited = 0;
    while (cmd_count < target && waited < 3 * CMD_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    assert (cmd_count >= target) else begin
      $display("Command %0d never completed on uart_txd", target);
      error_count++;
    end
  endtask

  // Line must stay high and the sequencer idle
  task automatic check_quiet();
    int low_cycles;
    axil_data_t rd;
    low_cycles = 0;
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      if (!uart_txd) begin
        low_cycles++;
      end
    end
    check_value("uart_txd low cycles", 32'(low_cycles), 32'h0);
    read_reg(REG_STATUS, rd);
    check_value("REG_STATUS", rd, 32'h0);
  endtask

  // --------------------
  // Line decoder
  // --------------------

  // Samples the middle of each bit on a falling clock edge
  initial begin : line_decoder
    uart_byte_t rx_byte;
    @(negedge reset);
    forever begin
      @(negedge uart_txd);
      repeat (BIT_CYCLES / 2) @(negedge clk);
      assert (uart_txd == 1'b0) else begin
        $display("Start bit on uart_txd ended before its middle at %0t", $time);
        error_count++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        rx_byte[i] = uart_txd;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      assert (uart_txd == 1'b1) else begin
        $display("[ERROR] uart_txd stop bit: got %h, expected %h", uart_txd, 1'b1);
        error_count++;
      end
      rx_q.push_back(rx_byte);
      rx_count++;
    end
  end

  // --------------------
  // Compare
  // --------------------

  initial begin : compare
    uart_byte_t got;
    logic [8*CMD_LEN-1:0] exp_cmd;
    int byte_pos;
    byte_pos = 0;
    exp_cmd = '0;
    forever begin
      @(negedge clk);
      while (rx_q.size() > 0) begin
        got = rx_q.pop_front();
        // A new command takes the next due frequency
        if (byte_pos == 0) begin
          assert (exp_q.size() != 0) else begin
            $display("A command began on uart_txd with no frequency due at %0t", $time);
            error_count++;
          end
          exp_cmd = (exp_q.size() != 0) ? expected_cmd(exp_q.pop_front()) : '0;
        end
        check_count++;
        assert (got == exp_cmd[8*byte_pos +: 8]) else begin
          $display("[ERROR] uart_txd byte %0d: got %h, expected %h",
                   byte_pos, got, exp_cmd[8*byte_pos +: 8]);
          error_count++;
        end
        if (byte_pos == int'(CMD_LEN) - 1) begin
          byte_pos = 0;
          cmd_count++;
        end else begin
          byte_pos++;
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  initial begin : stimulus
    logic [1:0] resp;
    axil_data_t rd;
    freq_t      f;
    freq_t      last_sent;
    int         n;
    int         base;
    int         waited;
    reset      = 1'b1;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    lfsr_state = LFSR_SEED;
    last_sent  = '0;
    n          = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle after reset
    // Zero matches the last sent value
    check_quiet();
    read_reg(REG_FREQ, rd);
    check_value("REG_FREQ", rd, 32'h0);
    write_reg(REG_FREQ, 32'h0, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    check_quiet();

    // Single writes of fixed then random values
    for (int i = 0; i < N_FIXED + N_RANDOM; i++) begin
      if (i < N_FIXED) begin
        f = FIXED_FREQS[i];
      end else begin
        take_random_freq(f);
      end
      if (f == last_sent) begin
        f = (f + 32'd1) % FREQ_LIMIT;
      end
      send_freq(f);
      n++;
      wait_commands(n);
      read_reg(REG_FREQ, rd);
      check_value("REG_FREQ", rd, f);
      last_sent = f;
    end

    // Same value again sends nothing
    write_reg(REG_FREQ, last_sent, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    check_quiet();

    // Burst while the first command is on the line
    base = rx_count;
    send_freq(32'd21_074_000);
    n++;
    waited = 0;
    while (rx_count == base && waited < 2 * FRAME_CYCLES + 200) begin
      @(negedge clk);
      waited++;
    end
    write_reg(REG_FREQ, 32'd28_074_000, resp);
    check_value("bresp", 32'(resp), 32'(RESP_OKAY));
    send_freq(32'd50_313_000);
    n++;
    // Busy and pending both set
    read_reg(REG_STATUS, rd);
    check_value("REG_STATUS", rd, 32'h3);
    wait_commands(n);
    read_reg(REG_STATUS, rd);
    check_value("REG_STATUS", rd, 32'h0);
    last_sent = 32'd50_313_000;

    // Refused writes leave the register alone
    write_reg(REG_FREQ, FREQ_LIMIT, resp);
    check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
    write_reg(REG_FREQ, 32'hffff_ffff, resp);
    check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
    write_reg(4'h8, 32'd3_573_000, resp);
    check_value("bresp", 32'(resp), 32'(RESP_SLVERR));
    read_reg(REG_FREQ, rd);
    check_value("REG_FREQ", rd, last_sent);
    check_quiet();

    check_value("commands still due", 32'(exp_q.size()), 32'h0);
    repeat (10) @(negedge clk);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, dut.u_assert.fail_count);
    if (error_count == 0 && dut.u_assert.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Bounded by the commands and quiet windows above
  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout, the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* build.f */
uart_pkg.sv
cat_pkg.sv
axil_freq_regs.sv
bin_to_bcd.sv
cat_cmd_sequencer.sv
uart_tx.sv
ext_amp_ctrl.sv
ext_amp_ctrl_assertions.sv
tb_ext_amp_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the ext_amp_ctrl testbench
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_ext_amp_ctrl \
  -o sim_ext_amp_ctrl > build.log 2>&1 &&
  ./obj_dir/sim_ext_amp_ctrl > sim.log 2>&1 ||
  echo "run_sim: build or run stopped with an error, see build.log and sim.log"
grep -q "SIMULATION PASSED" sim.log 2>/dev/null && echo "run_sim: passed" && exit 0 ||
  { echo "run_sim: failed"; exit 1; }
